// ==== hdl/alu.sv ====
`include "rv_consts.svh"

module alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::alu_op_e     alu_op,
  output logic [`RV_XLEN-1:0] result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic                add_cin;
  logic [`RV_XLEN-1:0] add_b;
  logic [`RV_XLEN-1:0] add_sum;
  logic [SHAMT_W-1:0]  shamt;

  // sub is a + ~b + 1 through the same adder
  assign add_cin = (alu_op == rv_pkg::alu_sub);
  assign add_b   = add_cin ? ~b : b;

  cla_adder cla_adder_inst (
    .a   (a),
    .b   (add_b),
    .cin (add_cin),
    .sum (add_sum)
  );

  // only the low bits of b count as the shift amount
  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add,
      rv_pkg::alu_sub:    result = add_sum;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {{(`RV_XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:   result = {{(`RV_XLEN - 1){1'b0}}, a < b};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      // arithmetic shift fills from the sign bit of a
      rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

endmodule

// ==== hdl/branch_unit.sv ====
`include "rv_consts.svh"

module branch_unit (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic                is_branch,
  input  rv_pkg::br_cond_e    br_cond,
  input  logic [`RV_XLEN-1:0] branch_imm,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic eq;
  logic lt_s;
  logic lt_u;
  logic taken;

  // three compares cover all six conditions
  // the ge forms are just the inverted lt results
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (br_cond)
      rv_pkg::beq:  taken = eq;
      rv_pkg::bne:  taken = !eq;
      rv_pkg::blt:  taken = lt_s;
      rv_pkg::bge:  taken = !lt_s;
      rv_pkg::bltu: taken = lt_u;
      rv_pkg::bgeu: taken = !lt_u;
      default:      taken = 1'b0;
    endcase
  end

  // branch offsets are relative to the branch itself
  assign next_pc = (is_branch && taken) ? pc + branch_imm : pc + `RV_PC_STEP;

  // without compressed instructions a taken branch to a half-word target is a
  // program error that would otherwise go on silently
  always_comb begin
    if (!$isunknown(pc)) begin
      assert (next_pc[1:0] == 2'b00)
        else $error("branch_unit: next_pc %h is not word aligned", next_pc);
    end
  end

endmodule

// ==== hdl/cla_adder.sv ====
`include "rv_consts.svh"

module cla_adder (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  logic                cin,
  output logic [`RV_XLEN-1:0] sum
);

  localparam int GRP_W = 4;
  localparam int NUM_GRP = `RV_XLEN / GRP_W;
  // one lookahead width serves both the bits of a group and the groups themselves
  localparam int LA_W = (GRP_W > NUM_GRP) ? GRP_W : NUM_GRP;

  logic [`RV_XLEN-1:0] gen;
  logic [`RV_XLEN-1:0] prop;
  logic [`RV_XLEN-1:0] carry;
  logic [LA_W-1:0]     grp_gen;
  logic [LA_W-1:0]     grp_prop;
  logic [NUM_GRP-1:0]  grp_cin;

  // carry into position n, written out as a flat sum of products
  // every term reaches back to c0 directly so no carry waits on another
  function automatic logic lookahead(input logic [LA_W-1:0] g, input logic [LA_W-1:0] p,
                                     input logic c0, input int n);
    logic c;
    logic term;
    c = c0;
    for (int m = 0; m < n; m++) begin
      c = c & p[m];
    end
    for (int j = 0; j < n; j++) begin
      term = g[j];
      for (int m = j + 1; m < n; m++) begin
        term = term & p[m];
      end
      c = c | term;
    end
    return c;
  endfunction

  assign gen  = a & b;
  assign prop = a ^ b;

  // group generate is the carry out of the group with no carry in
  always_comb begin
    logic [LA_W-1:0] bit_g;
    logic [LA_W-1:0] bit_p;
    grp_gen  = '0;
    grp_prop = '0;
    for (int k = 0; k < NUM_GRP; k++) begin
      bit_g = '0;
      bit_p = '0;
      bit_g[GRP_W-1:0] = gen[k*GRP_W +: GRP_W];
      bit_p[GRP_W-1:0] = prop[k*GRP_W +: GRP_W];
      grp_gen[k]  = lookahead(bit_g, bit_p, 1'b0, GRP_W);
      grp_prop[k] = &prop[k*GRP_W +: GRP_W];
    end
  end

  // second level resolves the carry into each group from cin alone
  always_comb begin
    for (int k = 0; k < NUM_GRP; k++) begin
      grp_cin[k] = lookahead(grp_gen, grp_prop, cin, k);
    end
  end

  // inside a group the bit carries start from that group's carry in
  always_comb begin
    logic [LA_W-1:0] bit_g;
    logic [LA_W-1:0] bit_p;
    for (int k = 0; k < NUM_GRP; k++) begin
      bit_g = '0;
      bit_p = '0;
      bit_g[GRP_W-1:0] = gen[k*GRP_W +: GRP_W];
      bit_p[GRP_W-1:0] = prop[k*GRP_W +: GRP_W];
      for (int i = 0; i < GRP_W; i++) begin
        carry[k*GRP_W + i] = lookahead(bit_g, bit_p, grp_cin[k], i);
      end
    end
  end

  assign sum = prop ^ carry;

endmodule

// ==== hdl/insn_decode.sv ====
`include "rv_consts.svh"

module insn_decode (
  input  logic [`RV_INSN_W-1:0]     insn,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic                      reg_we,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      use_imm,
  output logic [`RV_XLEN-1:0]       imm,
  output logic                      is_branch,
  output rv_pkg::br_cond_e          br_cond,
  output logic [`RV_XLEN-1:0]       branch_imm,
  output logic                      halt
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_shamt;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = rv_pkg::opcode_e'(insn[`RV_F_OPCODE]);
  assign funct3 = insn[`RV_F_FUNCT3];
  assign funct7 = insn[`RV_F_FUNCT7];

  // register indices sit in the same place in every format
  assign rs1 = insn[`RV_F_RS1];
  assign rs2 = insn[`RV_F_RS2];
  assign rd  = insn[`RV_F_RD];

  // I format carries a 12-bit signed immediate in the top bits
  assign imm_i = {{(`RV_XLEN - 12){insn[31]}}, insn[31:20]};
  // shift amount lives in the rs2 slot and is never sign extended
  assign imm_shamt = {{(`RV_XLEN - `RV_REG_ADDR_W){1'b0}}, insn[`RV_F_RS2]};
  // U format fills the upper 20 bits
  assign imm_u = {insn[31:12], 12'b0};
  // B format scatters a 13-bit even offset over the funct7 and rd slots
  assign branch_imm = {{(`RV_XLEN - 13){insn[31]}}, insn[31], insn[7], insn[30:25],
                       insn[11:8], 1'b0};

  always_comb begin
    reg_we    = 1'b0;
    alu_op    = rv_pkg::alu_add;
    use_imm   = 1'b0;
    imm       = '0;
    is_branch = 1'b0;
    br_cond   = rv_pkg::beq;
    halt      = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        // rs1 is not meaningful here so the alu just forwards operand b
        reg_we  = 1'b1;
        alu_op  = rv_pkg::alu_pass_b;
        use_imm = 1'b1;
        imm     = imm_u;
      end
      rv_pkg::op_reg_imm: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_i;
        case (funct3)
          3'b000: alu_op = rv_pkg::alu_add;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b011: alu_op = rv_pkg::alu_sltu;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b110: alu_op = rv_pkg::alu_or;
          3'b111: alu_op = rv_pkg::alu_and;
          3'b001: begin
            imm    = imm_shamt;
            alu_op = rv_pkg::alu_sll;
            reg_we = (funct7 == 7'b0);
          end
          default: begin
            // srli and srai share funct3 and differ only in funct7
            imm    = imm_shamt;
            alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            reg_we = (funct7 == 7'b0) || (funct7 == `RV_FUNCT7_ALT);
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        // only add/sub and srl/sra accept the alternate funct7
        reg_we = (funct7 == 7'b0) ||
                 (funct7 == `RV_FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000: alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001: alu_op = rv_pkg::alu_sll;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b011: alu_op = rv_pkg::alu_sltu;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110: alu_op = rv_pkg::alu_or;
          default: alu_op = rv_pkg::alu_and;
        endcase
      end
      rv_pkg::op_branch: begin
        is_branch = 1'b1;
        case (funct3)
          3'b000: br_cond = rv_pkg::beq;
          3'b001: br_cond = rv_pkg::bne;
          3'b100: br_cond = rv_pkg::blt;
          3'b101: br_cond = rv_pkg::bge;
          3'b110: br_cond = rv_pkg::bltu;
          3'b111: br_cond = rv_pkg::bgeu;
          default: is_branch = 1'b0;
        endcase
      end
      rv_pkg::op_environ: begin
        // ecall is the only environment call with all other fields clear
        halt = (funct7 == 7'b0) && (rs2 == '0) && (rs1 == '0) && (funct3 == 3'b0) &&
               (rd == '0);
      end
      default: begin
        // unknown opcodes keep the defaults and fall through to pc + 4
        reg_we = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/reg_file.sv ====
`include "rv_consts.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]       rd_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // both read ports are combinational so the same cycle can use the operands
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // reset zeroes the whole file and x0 is never written afterwards
  // so it keeps reading zero without a separate mux on the read side
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 must still read zero after any number of writes aimed at it
  a_x0_zero : assert property (@(posedge clk) disable iff (rst)
    ((rs1 == '0) -> (rs1_data == '0)) && ((rs2 == '0) -> (rs2_data == '0)))
    else $error("reg_file: x0 read back a nonzero value");

endmodule

// ==== hdl/rv_core.sv ====
`include "rv_consts.svh"

module rv_core (
  input  logic                      clk,
  input  logic                      rst,
  output logic [`RV_XLEN-1:0]       pc,
  input  logic [`RV_INSN_W-1:0]     insn,
  output logic                      halt,
  output logic [`RV_XLEN-1:0]       trace_pc,
  output logic [`RV_INSN_W-1:0]     trace_insn,
  output logic                      wb_we,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data
);

  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic                      reg_we;
  rv_pkg::alu_op_e           alu_op;
  logic                      use_imm;
  logic [`RV_XLEN-1:0]       imm;
  logic                      is_branch;
  rv_pkg::br_cond_e          br_cond;
  logic [`RV_XLEN-1:0]       branch_imm;
  logic [`RV_XLEN-1:0]       alu_b;
  logic [`RV_XLEN-1:0]       alu_result;
  logic [`RV_XLEN-1:0]       next_pc;

  // the pc is the only state outside the register file
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  insn_decode insn_decode_inst (
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .reg_we     (reg_we),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .imm        (imm),
    .is_branch  (is_branch),
    .br_cond    (br_cond),
    .branch_imm (branch_imm),
    .halt       (halt)
  );

  // the result is written at the end of the cycle and read back from the next one
  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_we),
    .rd       (rd),
    .rd_data  (alu_result)
  );

  // operand b is the immediate for lui and the register-immediate group
  assign alu_b = use_imm ? imm : rs2_data;

  alu alu_inst (
    .a      (rs1_data),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result)
  );

  branch_unit branch_unit_inst (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .is_branch  (is_branch),
    .br_cond    (br_cond),
    .branch_imm (branch_imm),
    .next_pc    (next_pc)
  );

  // trace and write-back describe the instruction retiring this cycle
  assign trace_pc   = pc;
  assign trace_insn = insn;
  assign wb_we      = reg_we;
  assign wb_rd      = rd;
  assign wb_data    = alu_result;

  // an ecall must never also update a register
  a_halt_no_write : assert property (@(posedge clk) disable iff (rst) halt |-> !wb_we)
    else $error("rv_core: wb_we high together with halt at pc %h", pc);

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  // major opcodes of the instruction groups this core executes
  // anything else decodes as a no-op that only advances the pc
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_branch  = 7'b1100011,
    op_environ = 7'b1110011
  } opcode_e;

  // operations of the alu
  // add and sub both go through the lookahead adder
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui result comes straight from operand b
    alu_pass_b
  } alu_op_e;

  // branch conditions take the funct3 encoding directly
  // 3'b010 and 3'b011 are not branches in RV32I
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } br_cond_e;

endpackage

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// register and datapath width of the RV32I core
`define RV_XLEN 32
// machine code is one 32-bit word per instruction
`define RV_INSN_W 32
// architectural registers x0 to x31
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// sequential fetch advances one word
`define RV_PC_STEP 32'd4
`define RV_RESET_PC 32'd0

// instruction field positions shared by every format
`define RV_F_OPCODE 6:0
`define RV_F_RD 11:7
`define RV_F_FUNCT3 14:12
`define RV_F_RS1 19:15
`define RV_F_RS2 24:20
`define RV_F_FUNCT7 31:25

// funct7 value that turns add into sub and srl into sra
`define RV_FUNCT7_ALT 7'b0100000

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compiles the testbench and core with Verilator, then runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim

output=$(./obj_dir/rv_core_sim || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx 'test passed'

// ==== rv_core.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/insn_decode.sv
hdl/cla_adder.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/rv_core.sv
tb/rv_core_tb.sv

// ==== tb/rv_core_tb.sv ====
`include "rv_consts.svh"

module rv_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 16;
  localparam int SEED = 24459;
  localparam int ROM_AW = 8;
  localparam int ROM_DEPTH = 1 << ROM_AW;
  // cycles the watchdog grants on top of one cycle per program word
  localparam int WATCHDOG_MARGIN = 50;
  // custom-0 opcode that this core treats as a plain pc + 4
  localparam logic [6:0] NOP_OPCODE = 7'b0001011;

  localparam logic [2:0] T_PC_STEP = 3'd0;
  localparam logic [2:0] T_REG_IMM = 3'd1;
  localparam logic [2:0] T_REG_REG = 3'd2;
  localparam logic [2:0] T_X0 = 3'd3;
  localparam logic [2:0] T_BRANCH = 3'd4;
  localparam logic [2:0] T_ECALL = 3'd5;

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  logic [`RV_INSN_W-1:0]     insn = '0;
  logic [`RV_XLEN-1:0]       pc;
  logic                      halt;
  logic [`RV_XLEN-1:0]       trace_pc;
  logic [`RV_INSN_W-1:0]     trace_insn;
  logic                      wb_we;
  logic [`RV_REG_ADDR_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]       wb_data;

  // program words and the test each word belongs to
  logic [31:0] rom [ROM_DEPTH];
  logic [2:0]  test_of [ROM_DEPTH];
  int          prog_len = 0;
  logic        rom_ready = 1'b0;

  // shadow architectural state and the prediction for the instruction in flight
  logic [31:0] mregs [`RV_NUM_REGS];
  logic [31:0] model_pc = '0;
  logic [31:0] exp_pc = '0;
  logic [31:0] exp_data = '0;
  logic [4:0]  exp_rd = '0;
  logic        exp_we = 1'b0;
  logic        exp_halt = 1'b0;

  int         reset_cycles = 0;
  logic [2:0] active_test = T_PC_STEP;
  string      test_names [6] = '{"pc_step", "reg_imm", "reg_reg", "x0_write", "branch", "ecall"};
  int         test_errors [6] = '{0, 0, 0, 0, 0, 0};
  int         tests_done = 0;
  int         tests_failing = 0;
  int         error_count = 0;

  rv_core rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .halt       (halt),
    .trace_pc   (trace_pc),
    .trace_insn (trace_insn),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic void flag_mismatch(input string what, input logic [31:0] expected,
                                        input logic [31:0] actual);
    $display("error %s: %s expected %h actual %h", test_names[active_test], what,
             expected, actual);
    test_errors[active_test]++;
    error_count++;
  endfunction

  function automatic void log_failure(input string what);
    $display("%s: %s", test_names[active_test], what);
    test_errors[active_test]++;
    error_count++;
  endfunction

  function automatic void finish_test(input logic [2:0] id);
    tests_done++;
    if (test_errors[id] == 0) begin
      $display("%-9s pass", test_names[id]);
    end else begin
      tests_failing++;
      $display("%-9s fail with %0d errors", test_names[id], test_errors[id]);
    end
  endfunction

  // instruction encoders for the formats the program uses
  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_pkg::op_reg_imm};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_pkg::op_lui};
  endfunction

  // the branch offset is even, so bit 0 is not encoded
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I branch conditions keyed by funct3
  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // integer results by funct3 where alt selects sub or sra
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic emit(input logic [2:0] test_id, input logic [31:0] word);
    rom[ROM_AW'(prog_len)] = word;
    test_of[ROM_AW'(prog_len)] = test_id;
    prog_len++;
  endtask

  // draws two 12-bit operands until the branch condition gives the wanted outcome
  task automatic pick_operands(input logic [2:0] f3, input logic want,
                               output logic [11:0] va, output logic [11:0] vb);
    logic [31:0] rnd;
    do begin
      rnd = $urandom;
      va = rnd[11:0];
      vb = rnd[27:16];
      // equal operands would almost never come up by chance
      if (rnd[31]) begin
        vb = va;
      end
    end while (branch_taken(f3, sext12(va), sext12(vb)) != want);
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [11:0] va;
    logic [11:0] vb;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rd;
    int          skip;
    // words past the program stay no-ops that still differ per address
    for (int i = 0; i < ROM_DEPTH; i++) begin
      rom[ROM_AW'(i)] = {i[24:0], NOP_OPCODE};
      test_of[ROM_AW'(i)] = T_ECALL;
    end
    repeat (4) begin
      rnd = $urandom;
      emit(T_PC_STEP, {rnd[31:7], NOP_OPCODE});
    end
    // fill every register with a random upper part before mixing them
    for (int r = 1; r < `RV_NUM_REGS; r++) begin
      rnd = $urandom;
      emit(T_REG_IMM, u_type(rnd[31:12], 5'(r)));
    end
    // funct3 walks through every operation so each one comes up several times
    for (int n = 0; n < 40; n++) begin
      rnd = $urandom;
      rd = 5'(1 + $urandom % 31);
      ra = 5'($urandom);
      f3 = 3'(n);
      if (n % 9 == 8) begin
        emit(T_REG_IMM, u_type(rnd[31:12], rd));
      end else begin
        imm = rnd[31:20];
        // shift immediates carry funct7 in their upper bits
        if (f3 == 3'd1) begin
          imm = {7'h00, rnd[24:20]};
        end
        if (f3 == 3'd5) begin
          imm = {n[3] ? 7'h20 : 7'h00, rnd[24:20]};
        end
        emit(T_REG_IMM, i_type(imm, ra, f3, rd));
      end
    end
    for (int n = 0; n < 40; n++) begin
      f3 = 3'(n);
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && n[3]) ? 7'h20 : 7'h00;
      emit(T_REG_REG, r_type(f7, 5'($urandom), 5'($urandom), f3, 5'(1 + $urandom % 31)));
    end
    // writes aimed at x0, then reads of x0 through add and sub
    ra = 5'(1 + $urandom % 31);
    emit(T_X0, i_type(12'($urandom), ra, 3'd0, 5'd0));
    emit(T_X0, u_type(20'($urandom), 5'd0));
    emit(T_X0, r_type(7'h00, ra, 5'd0, 3'd0, 5'd5));
    emit(T_X0, r_type(7'h00, 5'd0, ra, 3'd0, 5'd6));
    emit(T_X0, r_type(7'h20, 5'd0, ra, 3'd0, 5'd7));
    // each branch taken and then not taken, jumping over a few no-ops
    for (int c = 0; c < 8; c++) begin
      if (c != 2 && c != 3) begin
        for (int want = 1; want >= 0; want--) begin
          pick_operands(3'(c), want == 1, va, vb);
          ra = 5'(1 + $urandom % 15);
          rb = 5'(16 + $urandom % 15);
          emit(T_BRANCH, i_type(va, 5'd0, 3'd0, ra));
          emit(T_BRANCH, i_type(vb, 5'd0, 3'd0, rb));
          skip = 1 + int'($urandom % 3);
          emit(T_BRANCH, b_type(13'(4 * (skip + 1)), rb, ra, 3'(c)));
          repeat (skip) begin
            rnd = $urandom;
            emit(T_BRANCH, {rnd[31:7], NOP_OPCODE});
          end
        end
      end
    end
    emit(T_ECALL, 32'h0000_0073);
  endtask

  // fetches the word at the DUT pc and predicts what the core must do with it
  task automatic step_model();
    logic [ROM_AW-1:0] idx;
    logic [2:0]        f3;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       nxt;
    idx = pc[ROM_AW+1:2];
    insn = rom[idx];
    if (test_of[idx] != active_test) begin
      finish_test(active_test);
      active_test = test_of[idx];
    end
    f3 = insn[14:12];
    a = mregs[insn[19:15]];
    b = mregs[insn[24:20]];
    exp_pc = model_pc;
    exp_rd = insn[11:7];
    exp_we = 1'b0;
    exp_data = '0;
    exp_halt = 1'b0;
    nxt = model_pc + 32'd4;
    case (insn[6:0])
      rv_pkg::op_lui: begin
        exp_we = 1'b1;
        exp_data = {insn[31:12], 12'h000};
      end
      rv_pkg::op_reg_imm: begin
        exp_we = 1'b1;
        exp_data = alu_expect(f3, f3 == 3'd5 && insn[30], a, sext12(insn[31:20]));
      end
      rv_pkg::op_reg_reg: begin
        exp_we = 1'b1;
        exp_data = alu_expect(f3, insn[30], a, b);
      end
      rv_pkg::op_branch: begin
        if (branch_taken(f3, a, b)) begin
          nxt = model_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      rv_pkg::op_environ: exp_halt = (insn == 32'h0000_0073);
      default: exp_we = 1'b0;
    endcase
    // x0 stays zero in the model because it is never written
    if (exp_we && exp_rd != 5'd0) begin
      mregs[exp_rd] = exp_data;
    end
    model_pc = nxt;
  endtask

  // reset release and every new instruction happen on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      reset_cycles++;
      if (reset_cycles == RESET_CYCLES) begin
        rst = 1'b0;
        model_pc = `RV_RESET_PC;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
          mregs[5'(i)] = '0;
        end
        assert (pc == `RV_RESET_PC)
          else flag_mismatch("pc after reset", `RV_RESET_PC, pc);
        step_model();
      end
    end else begin
      step_model();
    end
  end

  // the rising edge samples the settled outputs of the instruction driven before it
  a_pc : assert property (@(posedge clk) disable iff (rst) pc == exp_pc)
    else flag_mismatch("pc", exp_pc, $sampled(pc));
  a_trace_pc : assert property (@(posedge clk) disable iff (rst) trace_pc == exp_pc)
    else flag_mismatch("trace_pc", exp_pc, $sampled(trace_pc));
  a_trace_insn : assert property (@(posedge clk) disable iff (rst) trace_insn == insn)
    else flag_mismatch("trace_insn", insn, $sampled(trace_insn));
  a_we : assert property (@(posedge clk) disable iff (rst) wb_we == exp_we)
    else flag_mismatch("wb_we", 32'(exp_we), 32'($sampled(wb_we)));
  a_rd : assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_rd == exp_rd)
    else flag_mismatch("wb_rd", 32'(exp_rd), 32'($sampled(wb_rd)));
  a_data : assert property (@(posedge clk) disable iff (rst) exp_we |-> wb_data == exp_data)
    else flag_mismatch("wb_data", exp_data, $sampled(wb_data));
  a_halt : assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
    else flag_mismatch("halt", 32'(exp_halt), 32'($sampled(halt)));
  a_halt_quiet : assert property (@(posedge clk) disable iff (rst) halt |-> !wb_we)
    else log_failure("wb_we was high while halt was raised");

  // one cycle per program word after reset and a margin on top
  initial begin
    wait (rom_ready);
    #((RESET_CYCLES + prog_len + WATCHDOG_MARGIN) * CLK_PERIOD);
    $display("timeout: the core never raised halt within %0d cycles",
             RESET_CYCLES + prog_len + WATCHDOG_MARGIN);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    build_program();
    rom_ready = 1'b1;
    // halt follows insn alone, so it is steady at the rising edge
    do begin
      @(posedge clk);
    end while (rst || halt !== 1'b1);
    #1;
    finish_test(active_test);
    $display("%0d tests, %0d failing, %0d errors", tests_done, tests_failing, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
